// ==== vlog.f ====
+incdir+source
+incdir+testbench
source/timerPkg.sv
source/opcodeCycleTable.sv
source/systemCounter.sv
source/timaCounter.sv
source/timerUnit.sv
testbench/timerUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the timer testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module timerUnitTb -f vlog.f -o simTimer

status=0
./obj_dir/simTimer > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^Test passed$" sim.log
then
    exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1

// ==== testbench/cycleCostRef.svh ====
`ifndef CYCLE_COST_REF_SVH
`define CYCLE_COST_REF_SVH

// Machine cycles per instruction, taken from the published SM83 timing table.
// 0 means the opcode does not exist
function automatic timerPkg::mCyclesT instrCycles(
    input timerPkg::opcodeT op,
    input logic             cbPage,
    input logic             taken
);
    timerPkg::mCyclesT cycles;
    if (cbPage)
    begin
        // Register operand 2, BIT n,(HL) 3, other (HL) forms 4
        if (op[2:0] != 3'd6)
        begin
            cycles = 3'd2;
        end
        else if (op[7:6] == 2'b01)
        begin
            cycles = 3'd3;
        end
        else
        begin
            cycles = 3'd4;
        end
    end
    else if (op >= 8'h40 && op <= 8'hBF)
    begin
        // LD r,r' and ALU block, a memory operand costs one more
        if (op == 8'h76)
        begin
            cycles = 3'd1;
        end
        else if (op[2:0] == 3'd6 || op[7:3] == 5'b01110)
        begin
            cycles = 3'd2;
        end
        else
        begin
            cycles = 3'd1;
        end
    end
    else
    begin
        case (op)
            8'h00, 8'h04, 8'h05, 8'h07, 8'h0C, 8'h0D, 8'h0F, 8'h10, 8'h14, 8'h15,
            8'h17, 8'h1C, 8'h1D, 8'h1F, 8'h24, 8'h25, 8'h27, 8'h2C, 8'h2D, 8'h2F,
            8'h37, 8'h3C, 8'h3D, 8'h3F, 8'hE9, 8'hF3, 8'hFB:
                cycles = 3'd1;
            8'h01, 8'h11, 8'h21, 8'h31, 8'h18, 8'h34, 8'h35, 8'h36, 8'hC1, 8'hD1,
            8'hE1, 8'hF1, 8'hE0, 8'hF0, 8'hF8, 8'hC2, 8'hCA, 8'hD2, 8'hDA, 8'hC4,
            8'hCC, 8'hD4, 8'hDC:
                cycles = 3'd3;
            8'hC3, 8'hC5, 8'hC7, 8'hC9, 8'hCF, 8'hD5, 8'hD7, 8'hD9, 8'hDF, 8'hE5,
            8'hE7, 8'hE8, 8'hEA, 8'hEF, 8'hF5, 8'hF7, 8'hFA, 8'hFF:
                cycles = 3'd4;
            8'h08:
                cycles = 3'd5;
            8'hCD:
                cycles = 3'd6;
            8'hCB, 8'hD3, 8'hDB, 8'hDD, 8'hE3, 8'hE4, 8'hEB, 8'hEC, 8'hED, 8'hF4,
            8'hFC, 8'hFD:
                cycles = 3'd0;
            default:
                cycles = 3'd2;
        endcase
        // Conditional JR, JP, RET and CALL when the condition holds
        if (taken)
        begin
            case (op)
                8'h20, 8'h28, 8'h30, 8'h38: cycles = 3'd3;
                8'hC2, 8'hCA, 8'hD2, 8'hDA: cycles = 3'd4;
                8'hC0, 8'hC8, 8'hD0, 8'hD8: cycles = 3'd5;
                8'hC4, 8'hCC, 8'hD4, 8'hDC: cycles = 3'd6;
                default:                    cycles = cycles;
            endcase
        end
    end
    return cycles;
endfunction

`endif

// ==== testbench/timerUnitTb.sv ====
`timescale 1ns/10ps
`include "timer_macros.svh"

module timerUnitTb;

    localparam int CLOCK_PERIOD    = 8;
    localparam int RUN_INSTRS      = 300;
    localparam int SPEED_INSTRS    = 120;
    localparam int STOP_INSTRS     = 30;
    localparam int OVERFLOW_INSTRS = 30;
    // Random instructions take at most two cycles each, plus the directed steps
    localparam int TEST_CYCLES     = 2 * (RUN_INSTRS + 4 * (SPEED_INSTRS + STOP_INSTRS)
                                          + OVERFLOW_INSTRS) + 120;
    localparam int WATCHDOG_TIME   = TEST_CYCLES * CLOCK_PERIOD + 1000;

    logic                iClock;
    logic                rst;
    logic                eof;
    timerPkg::opcodeT    opcode;
    logic                prefixed;
    logic                branchTaken;
    logic                regWrite;
    timerPkg::timerRegE  regSelect;
    timerPkg::regByteT   writeData;
    timerPkg::regByteT   div;
    timerPkg::regByteT   tima;
    timerPkg::regByteT   tma;
    timerPkg::regByteT   tac;
    logic                irqTimer;

    // Reference model state
    timerPkg::sysCountT  modelCount;
    timerPkg::tickCountT modelTicks;
    timerPkg::regByteT   modelTima;
    timerPkg::regByteT   modelTma;
    timerPkg::regByteT   modelTac;
    logic                modelIrq;
    logic                pendValid;
    timerPkg::mCyclesT   pendCost;

    logic [31:0]         lfsrState;
    logic                checkOn;
    int                  irqSeen;
    int                  irqBefore;

    `include "cycleCostRef.svh"

    timerUnit dut_i
    (
        .iClock      (iClock),
        .rst         (rst),
        .eof         (eof),
        .opcode      (opcode),
        .prefixed    (prefixed),
        .branchTaken (branchTaken),
        .regWrite    (regWrite),
        .regSelect   (regSelect),
        .writeData   (writeData),
        .div         (div),
        .tima        (tima),
        .tma         (tma),
        .tac         (tac),
        .irqTimer    (irqTimer)
    );

    always #(CLOCK_PERIOD / 2) iClock = ~iClock;

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------

    // Feedback taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic takeBits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsrState = lfsrStep(lfsrState);
            bits      = {bits[30:0], lfsrState[0]};
        end
    endtask

    // Sets every DUT input for the next cycle
    task automatic driveCycle(
        input logic               endOfInstr,
        input timerPkg::opcodeT   op,
        input logic               cbPage,
        input logic               taken,
        input logic               wr,
        input timerPkg::timerRegE sel,
        input timerPkg::regByteT  data
    );
        @(posedge iClock);
        #1;
        eof         = endOfInstr;
        opcode      = op;
        prefixed    = cbPage;
        branchTaken = taken;
        regWrite    = wr;
        regSelect   = sel;
        writeData   = data;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) driveCycle(1'b0, 8'h00, 1'b0, 1'b0, 1'b0, timerPkg::divReg, 8'h00);
    endtask

    task automatic writeReg(input timerPkg::timerRegE sel, input timerPkg::regByteT data);
        driveCycle(1'b0, 8'h00, 1'b0, 1'b0, 1'b1, sel, data);
    endtask

    task automatic issueOpcode(input timerPkg::opcodeT op);
        driveCycle(1'b1, op, 1'b0, 1'b0, 1'b0, timerPkg::divReg, 8'h00);
    endtask

    // Random existing instruction, optionally followed by a gap cycle
    task automatic issueRandom(input logic allowGap);
        logic [31:0] bits;
        do
        begin
            takeBits(10, bits);
        end
        while (instrCycles(bits[7:0], bits[8], bits[9]) == 3'd0);
        driveCycle(1'b1, bits[7:0], bits[8], bits[9], 1'b0, timerPkg::divReg, 8'h00);
        takeBits(2, bits);
        if (allowGap && bits[1:0] == 2'b00)
        begin
            idle(1);
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model, follows the pipeline latencies of the timer
    // ------------------------------------------------------------------------
    function automatic int tapForSpeed(input logic [1:0] speed);
        case (speed)
            2'd0:    return `TAP_BIT_0;
            2'd1:    return `TAP_BIT_1;
            2'd2:    return `TAP_BIT_2;
            default: return `TAP_BIT_3;
        endcase
    endfunction

    always @(posedge iClock)
    begin : referenceModel
        int                 sum;
        int                 ticks;
        int                 tap;
        logic               prevBit;
        timerPkg::sysCountT count;
        timerPkg::regByteT  nextTima;
        logic               nextIrq;
        if (rst)
        begin
            modelCount = '0;
            modelTicks = '0;
            modelTima  = '0;
            modelTma   = '0;
            modelTac   = '0;
            modelIrq   = 1'b0;
            pendValid  = 1'b0;
            pendCost   = '0;
        end
        else
        begin
            // TIMA stage, ticks come from the counter update one edge earlier
            nextIrq  = 1'b0;
            nextTima = modelTima;
            sum      = int'(modelTima) + int'(modelTicks);
            if (regWrite && regSelect == timerPkg::timaReg)
            begin
                nextTima = writeData;
            end
            else if (modelTac[`TAC_ENABLE_BIT])
            begin
                if (sum > 255)
                begin
                    nextTima = modelTma + timerPkg::regByteT'(sum - 256);
                    nextIrq  = 1'b1;
                end
                else
                begin
                    nextTima = timerPkg::regByteT'(sum);
                end
            end

            // Counter stage, walked one clock at a time
            tap   = tapForSpeed(modelTac[1:0]);
            count = modelCount;
            ticks = 0;
            if (regWrite && regSelect == timerPkg::divReg)
            begin
                ticks = int'(count[tap]);
                count = '0;
            end
            else if (pendValid)
            begin
                for (int i = 0; i < int'(pendCost) * `CLOCKS_PER_MCYCLE; i++)
                begin
                    prevBit = count[tap];
                    count   = count + 16'd1;
                    if (prevBit && !count[tap])
                    begin
                        ticks++;
                    end
                end
            end

            // Cost stage
            pendValid = eof;
            pendCost  = eof ? instrCycles(opcode, prefixed, branchTaken) : 3'd0;

            if (regWrite && regSelect == timerPkg::tmaReg)
            begin
                modelTma = writeData;
            end
            if (regWrite && regSelect == timerPkg::tacReg)
            begin
                modelTac = writeData;
            end
            modelCount = count;
            modelTicks = timerPkg::tickCountT'(ticks);
            modelTima  = nextTima;
            modelIrq   = nextIrq;
        end
    end

    // ------------------------------------------------------------------------
    // Compare
    // ------------------------------------------------------------------------
    task automatic checkReg(
        input string             name,
        input timerPkg::regByteT actual,
        input timerPkg::regByteT expected
    );
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "Register mismatch");
        end
    endtask

    task automatic checkIrq(input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: irqTimer is %b, expected %b", $time, actual, expected);
            $display("Test failed");
            $fatal(1, "Interrupt mismatch");
        end
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge iClock)
    begin
        if (checkOn)
        begin
            checkReg("div", div, modelCount[`DIV_LSB +: 8]);
            checkReg("tima", tima, modelTima);
            checkReg("tma", tma, modelTma);
            checkReg("tac", tac, modelTac);
            checkIrq(irqTimer, modelIrq);
            if (irqTimer)
            begin
                irqSeen++;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display("Simulation timed out at %0t ns before all tests finished", $time);
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial
    begin
        iClock      = 1'b0;
        rst         = 1'b1;
        eof         = 1'b0;
        opcode      = '0;
        prefixed    = 1'b0;
        branchTaken = 1'b0;
        regWrite    = 1'b0;
        regSelect   = timerPkg::divReg;
        writeData   = '0;
        lfsrState   = 32'hcecb;
        checkOn     = 1'b0;
        irqSeen     = 0;
        repeat (2) @(posedge iClock);
        #1;
        rst     = 1'b0;
        checkOn = 1'b1;

        // Quiet after reset
        idle(4);

        // DIV follows the cost sum, timer stopped
        repeat (RUN_INSTRS) issueRandom(1'b1);
        idle(4);

        // Each speed running, then stopped
        for (int speed = 0; speed < 4; speed++)
        begin
            writeReg(timerPkg::tacReg, 8'h04 | 8'(speed));
            repeat (SPEED_INSTRS) issueRandom(1'b1);
            writeReg(timerPkg::tacReg, 8'(speed));
            repeat (STOP_INSTRS) issueRandom(1'b1);
        end
        idle(4);

        // Overflow and reload from TMA
        writeReg(timerPkg::tmaReg, 8'hA0);
        writeReg(timerPkg::tacReg, 8'h05);
        writeReg(timerPkg::timaReg, 8'hFD);
        irqBefore = irqSeen;
        repeat (OVERFLOW_INSTRS) issueRandom(1'b0);
        idle(4);
        if (irqSeen == irqBefore)
        begin
            $display("TIMA preset near 255 never raised the timer interrupt");
            $display("Test failed");
            $fatal(1, "No overflow");
        end

        // DIV write with tap bit 3 set counts a tick
        writeReg(timerPkg::divReg, 8'h00);
        idle(3);
        issueOpcode(8'h00);
        issueOpcode(8'h00);
        idle(3);
        writeReg(timerPkg::divReg, 8'h5A);
        idle(3);

        // Advance in the same cycle as a DIV write is lost
        issueOpcode(8'h00);
        writeReg(timerPkg::divReg, 8'h00);
        idle(3);

        // CALL crosses the tap edge, TIMA write lands with the tick
        issueOpcode(8'hCD);
        idle(1);
        writeReg(timerPkg::timaReg, 8'h42);
        idle(4);

        $display("Test passed");
        $finish;
    end

endmodule

// ==== source/timerUnit.sv ====
`timescale 1ns/10ps

module timerUnit
(
    input  logic               iClock,
    input  logic               rst,

    // End of instruction from the CPU
    input  logic               eof,
    input  timerPkg::opcodeT   opcode,
    input  logic               prefixed,
    input  logic               branchTaken,

    // Register write port
    input  logic               regWrite,
    input  timerPkg::timerRegE regSelect,
    input  timerPkg::regByteT  writeData,

    // Register values, 0xFF04 to 0xFF07
    output timerPkg::regByteT  div,
    output timerPkg::regByteT  tima,
    output timerPkg::regByteT  tma,
    output timerPkg::regByteT  tac,

    output logic               irqTimer
);

    logic                costValid;
    timerPkg::mCyclesT   cost;
    timerPkg::tickCountT timerTicks;
    logic [1:0]          tacSpeed;

    // ------------------------------------------------------------------------
    // Opcode to machine cycles
    // ------------------------------------------------------------------------
    opcodeCycleTable costTable
    (
        .iClock      (iClock),
        .rst         (rst),
        .eof         (eof),
        .opcode      (opcode),
        .prefixed    (prefixed),
        .branchTaken (branchTaken),
        .costValid   (costValid),
        .cost        (cost)
    );

    // ------------------------------------------------------------------------
    // System counter, DIV and tap edges
    // ------------------------------------------------------------------------
    systemCounter sysCounter
    (
        .iClock     (iClock),
        .rst        (rst),
        .costValid  (costValid),
        .cost       (cost),
        .tacSpeed   (tacSpeed),
        .regWrite   (regWrite),
        .regSelect  (regSelect),
        .writeData  (writeData),
        .div        (div),
        .timerTicks (timerTicks)
    );

    // ------------------------------------------------------------------------
    // TIMA, TMA, TAC and the interrupt
    // ------------------------------------------------------------------------
    timaCounter timaCount
    (
        .iClock     (iClock),
        .rst        (rst),
        .timerTicks (timerTicks),
        .regWrite   (regWrite),
        .regSelect  (regSelect),
        .writeData  (writeData),
        .tima       (tima),
        .tma        (tma),
        .tac        (tac),
        .tacSpeed   (tacSpeed),
        .irqTimer   (irqTimer)
    );

endmodule

// ==== source/timaCounter.sv ====
`timescale 1ns/10ps
`include "timer_macros.svh"

module timaCounter
(
    input  logic                iClock,
    input  logic                rst,
    input  timerPkg::tickCountT timerTicks,
    input  logic                regWrite,
    input  timerPkg::timerRegE  regSelect,
    input  timerPkg::regByteT   writeData,
    output timerPkg::regByteT   tima,
    output timerPkg::regByteT   tma,
    output timerPkg::regByteT   tac,
    output logic [1:0]          tacSpeed,
    output logic                irqTimer
);

    logic       timaWrite;
    logic       tmaWrite;
    logic       tacWrite;
    logic       tacEnable;
    logic [8:0] timaSum;
    logic       overflow;

    // ------------------------------------------------------------------------
    // Register decode
    // ------------------------------------------------------------------------
    assign timaWrite = regWrite && (regSelect == timerPkg::timaReg);
    assign tmaWrite  = regWrite && (regSelect == timerPkg::tmaReg);
    assign tacWrite  = regWrite && (regSelect == timerPkg::tacReg);

    // Speed code goes back to the system counter to pick the tap
    assign tacSpeed  = tac[1:0];
    assign tacEnable = tac[`TAC_ENABLE_BIT];

    // ------------------------------------------------------------------------
    // TIMA increment
    // Up to two ticks arrive at once, so a carry may leave one tick over
    // ------------------------------------------------------------------------
    assign timaSum  = {1'b0, tima} + {7'b0, timerTicks};
    assign overflow = tacEnable && timaSum[8];

    always_ff @(posedge iClock)
    begin
        if (rst)
        begin
            tima <= '0;
        end
        else if (timaWrite)
        begin
            // CPU write wins over a tick in the same cycle
            tima <= writeData;
        end
        else if (overflow)
        begin
            // Reload from TMA, plus the tick that passed the carry
            tima <= tma + timaSum[7:0];
        end
        else if (tacEnable)
        begin
            tima <= timaSum[7:0];
        end
    end

    // Modulo and control registers
    always_ff @(posedge iClock)
    begin
        if (rst)
        begin
            tma <= '0;
            tac <= '0;
        end
        else
        begin
            if (tmaWrite)
            begin
                tma <= writeData;
            end
            if (tacWrite)
            begin
                tac <= writeData;
            end
        end
    end

    // Interrupt 0x50, one cycle, in the cycle TIMA shows the reload
    always_ff @(posedge iClock)
    begin
        if (rst)
        begin
            irqTimer <= 1'b0;
        end
        else
        begin
            irqTimer <= overflow && !timaWrite;
        end
    end

    // A stopped timer never raises the interrupt
    noIrqWhenStopped: assert property (
        @(posedge iClock) disable iff (rst)
        irqTimer |-> $past(tac[`TAC_ENABLE_BIT])
    ) else $error("irqTimer pulsed while TAC was disabled");

endmodule

// ==== source/systemCounter.sv ====
`timescale 1ns/10ps
`include "timer_macros.svh"

module systemCounter
(
    input  logic                iClock,
    input  logic                rst,
    input  logic                costValid,
    input  timerPkg::mCyclesT   cost,
    input  logic [1:0]          tacSpeed,
    input  logic                regWrite,
    input  timerPkg::timerRegE  regSelect,
    input  timerPkg::regByteT   writeData,
    output timerPkg::regByteT   div,
    output timerPkg::tickCountT timerTicks
);

    timerPkg::sysCountT  sysCount;
    timerPkg::sysCountT  nextCount;
    timerPkg::sysCountT  advance;
    timerPkg::tickCountT nextTicks;
    logic [16:0]         oldWide;
    logic [16:0]         sumWide;
    logic [16:0]         edgeCount;
    logic [3:0]          tapIndex;
    logic                divWrite;

    // Any write to DIV clears the counter, writeData is not stored
    assign divWrite = regWrite && (regSelect == timerPkg::divReg);

    // Counter bit that clocks TIMA
    always_comb
    begin
        case (tacSpeed)
            2'd0:    tapIndex = 4'(`TAP_BIT_0);
            2'd1:    tapIndex = 4'(`TAP_BIT_1);
            2'd2:    tapIndex = 4'(`TAP_BIT_2);
            default: tapIndex = 4'(`TAP_BIT_3);
        endcase
    end

    // ------------------------------------------------------------------------
    // Advance and falling edge count
    // The 17th bit keeps the wrap, so 0xFFFF to 0 counts as an edge too
    // ------------------------------------------------------------------------
    always_comb
    begin
        advance   = costValid
                  ? timerPkg::sysCountT'(cost) * timerPkg::sysCountT'(`CLOCKS_PER_MCYCLE)
                  : '0;
        oldWide   = {1'b0, sysCount};
        sumWide   = oldWide + {1'b0, advance};
        // Falling edges equal the multiples of 2^(tap+1) crossed
        edgeCount = (sumWide >> (tapIndex + 1)) - (oldWide >> (tapIndex + 1));

        if (divWrite)
        begin
            // Clearing a set tap bit is itself a falling edge
            nextCount = '0;
            nextTicks = {1'b0, sysCount[tapIndex]};
        end
        else
        begin
            nextCount = sumWide[15:0];
            nextTicks = timerPkg::tickCountT'(edgeCount);
        end
    end

    always_ff @(posedge iClock)
    begin
        if (rst)
        begin
            sysCount   <= '0;
            timerTicks <= '0;
        end
        else
        begin
            sysCount   <= nextCount;
            timerTicks <= nextTicks;
        end
    end

    assign div = sysCount[`DIV_LSB +: 8];

    // Six machine cycles span at most two periods of the fastest tap
    ticksInRange: assert property (
        @(posedge iClock) disable iff (rst)
        timerTicks <= 2'd2
    ) else $error("timerTicks above 2");

endmodule

// ==== source/opcodeCycleTable.sv ====
`timescale 1ns/10ps

module opcodeCycleTable
(
    input  logic              iClock,
    input  logic              rst,
    input  logic              eof,
    input  timerPkg::opcodeT  opcode,
    input  logic              prefixed,
    input  logic              branchTaken,
    output logic              costValid,
    output timerPkg::mCyclesT cost
);

    // ------------------------------------------------------------------------
    // Cost tables
    // One 64-bit word per high opcode nibble, one hex digit per low nibble.
    // The leftmost digit is column 0
    // ------------------------------------------------------------------------

    // Unprefixed page, branches not taken
    localparam logic [63:0] baseRows [16] = '{
        64'h1322_1121_5222_1121,   // 0x
        64'h1322_1121_3222_1121,   // 1x
        64'h2322_1121_2222_1121,   // 2x
        64'h2322_3331_2222_1121,   // 3x
        64'h1111_1121_1111_1121,   // 4x
        64'h1111_1121_1111_1121,   // 5x
        64'h1111_1121_1111_1121,   // 6x
        64'h2222_2212_1111_1121,   // 7x
        64'h1111_1121_1111_1121,   // 8x
        64'h1111_1121_1111_1121,   // 9x
        64'h1111_1121_1111_1121,   // Ax
        64'h1111_1121_1111_1121,   // Bx
        64'h2334_3424_2430_3624,   // Cx
        64'h2330_3424_2430_3024,   // Dx
        64'h3320_0424_4140_0024,   // Ex
        64'h3321_0424_3241_0024    // Fx
    };

    // Conditional JR, JP, CALL and RET when the condition holds.
    // Every other opcode is 0 here, which is also how branches are recognised
    localparam logic [63:0] takenRows [16] = '{
        64'h0000_0000_0000_0000,   // 0x
        64'h0000_0000_0000_0000,   // 1x
        64'h3000_0000_3000_0000,   // 2x
        64'h3000_0000_3000_0000,   // 3x
        64'h0000_0000_0000_0000,   // 4x
        64'h0000_0000_0000_0000,   // 5x
        64'h0000_0000_0000_0000,   // 6x
        64'h0000_0000_0000_0000,   // 7x
        64'h0000_0000_0000_0000,   // 8x
        64'h0000_0000_0000_0000,   // 9x
        64'h0000_0000_0000_0000,   // Ax
        64'h0000_0000_0000_0000,   // Bx
        64'h5040_6000_5040_6000,   // Cx
        64'h5040_6000_5040_6000,   // Dx
        64'h0000_0000_0000_0000,   // Ex
        64'h0000_0000_0000_0000    // Fx
    };

    // 0xCB page, (HL) operands cost more, BIT n,(HL) only reads
    localparam logic [63:0] prefixRows [16] = '{
        64'h2222_2242_2222_2242,   // 0x rotates
        64'h2222_2242_2222_2242,   // 1x
        64'h2222_2242_2222_2242,   // 2x shifts
        64'h2222_2242_2222_2242,   // 3x swap, srl
        64'h2222_2232_2222_2232,   // 4x bit
        64'h2222_2232_2222_2232,   // 5x
        64'h2222_2232_2222_2232,   // 6x
        64'h2222_2232_2222_2232,   // 7x
        64'h2222_2242_2222_2242,   // 8x res
        64'h2222_2242_2222_2242,   // 9x
        64'h2222_2242_2222_2242,   // Ax
        64'h2222_2242_2222_2242,   // Bx
        64'h2222_2242_2222_2242,   // Cx set
        64'h2222_2242_2222_2242,   // Dx
        64'h2222_2242_2222_2242,   // Ex
        64'h2222_2242_2222_2242    // Fx
    };

    // Pick one digit out of a table row
    function automatic timerPkg::mCyclesT lookupCost(
        input logic [63:0] row,
        input logic [3:0]  column
    );
        int unsigned position;
        position = (15 - int'(column)) * 4;
        return row[position +: 3];
    endfunction

    timerPkg::mCyclesT baseCost;
    timerPkg::mCyclesT takenCost;
    timerPkg::mCyclesT prefixCost;
    timerPkg::mCyclesT selectedCost;
    logic              isBranch;

    assign baseCost   = lookupCost(baseRows[opcode[7:4]], opcode[3:0]);
    assign takenCost  = lookupCost(takenRows[opcode[7:4]], opcode[3:0]);
    assign prefixCost = lookupCost(prefixRows[opcode[7:4]], opcode[3:0]);
    assign isBranch   = (takenCost != '0);

    always_comb
    begin
        if (prefixed)
        begin
            selectedCost = prefixCost;
        end
        else if (isBranch && branchTaken)
        begin
            selectedCost = takenCost;
        end
        else
        begin
            selectedCost = baseCost;
        end
    end

    // ------------------------------------------------------------------------
    // Output register, one cycle behind eof
    // ------------------------------------------------------------------------
    always_ff @(posedge iClock)
    begin
        if (rst)
        begin
            costValid <= 1'b0;
        end
        else
        begin
            costValid <= eof;
        end
    end

    always_ff @(posedge iClock)
    begin
        if (eof)
        begin
            cost <= selectedCost;
        end
    end

    // A presented cost always belongs to an opcode that exists
    costFollowsEof: assert property (
        @(posedge iClock) disable iff (rst)
        costValid |-> (cost != '0)
    ) else $error("costValid with a zero cost, the opcode does not exist");

endmodule

// ==== source/timerPkg.sv ====
`include "timer_macros.svh"

package timerPkg;

    // ------------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------------

    // Instruction opcode, unprefixed or second byte after 0xCB
    typedef logic [`OPCODE_BITS-1:0] opcodeT;

    // Machine cycle cost, 0 marks an opcode that does not exist
    typedef logic [`MCYCLE_BITS-1:0] mCyclesT;

    // Free running clock counter, DIV is its upper byte
    typedef logic [`SYSCOUNT_BITS-1:0] sysCountT;

    // One timer register byte
    typedef logic [`REG_BITS-1:0] regByteT;

    // TIMA ticks produced by one counter update
    typedef logic [`TICK_BITS-1:0] tickCountT;

    // ------------------------------------------------------------------------
    // Register select
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        divReg  = `REG_SEL_DIV,
        timaReg = `REG_SEL_TIMA,
        tmaReg  = `REG_SEL_TMA,
        tacReg  = `REG_SEL_TAC
    } timerRegE;

endpackage

// ==== source/timer_macros.svh ====
`ifndef TIMER_MACROS_SVH
`define TIMER_MACROS_SVH

// Data path widths
`define OPCODE_BITS       8
`define MCYCLE_BITS       3
`define SYSCOUNT_BITS     16
`define REG_BITS          8
`define TICK_BITS         2

// Register select codes, matching 0xFF04 to 0xFF07
`define REG_SEL_DIV       2'd0
`define REG_SEL_TIMA      2'd1
`define REG_SEL_TMA       2'd2
`define REG_SEL_TAC       2'd3

// One machine cycle is four input clocks
`define CLOCKS_PER_MCYCLE 4

// System counter bit watched for each TAC speed code
`define TAP_BIT_0         9
`define TAP_BIT_1         3
`define TAP_BIT_2         5
`define TAP_BIT_3         7

// TAC run bit and the position of DIV inside the system counter
`define TAC_ENABLE_BIT    2
`define DIV_LSB           8

`endif
